//--- run.sh
#!/bin/sh
# Build and run the scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_job_sched -Mdir obj_dir

# A $fatal in the testbench gives a non-zero exit status
./obj_dir/Vtb_job_sched

//--- src/job_pkg.sv
`default_nettype none

// Job descriptor shared by the queue, the FSM and the top level
package job_pkg;

    parameter int ID_W   = 4;  // Job identifier
    parameter int PRIO_W = 3;  // Priority value
    parameter int LEN_W  = 4;  // Run length in cycles, 0 still runs one cycle

    // One queue entry, id in the top bits
    typedef struct packed {
        logic [ID_W-1:0]   id;    // Reported on done
        logic [PRIO_W-1:0] prio;  // Sort key
        logic [LEN_W-1:0]  len;   // Loaded into the timer
    } job_t;

    // 11 bits in all
    parameter int JOB_W = ID_W + PRIO_W + LEN_W;

endpackage

`default_nettype wire

//--- src/job_sched_top.sv
`timescale 1ns/1ps
`default_nettype none

module job_sched_top #(
    parameter int DEPTH_LOG2      = 3,    // 8 queue entries
    parameter bit HIGH_PRIO_FIRST = 1'b1
) (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_push,
    input  wire job_pkg::job_t        i_job,
    input  wire                       i_enable,
    output logic                      o_done,
    output logic [job_pkg::ID_W-1:0]  o_done_id,
    output sched_pkg::sched_status_t  o_status,
    output logic [DEPTH_LOG2:0]       o_count
);

    job_pkg::job_t             q_head;
    logic                      q_full;
    logic                      q_empty;
    logic                      fsm_pop;
    logic                      fsm_load;
    logic [job_pkg::LEN_W-1:0] fsm_len;
    logic                      fsm_busy;
    logic                      tmr_expire;

    prio_queue #(
        .DEPTH_LOG2      (DEPTH_LOG2),
        .HIGH_PRIO_FIRST (HIGH_PRIO_FIRST)
    ) u_prio_queue (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_push  (i_push),
        .i_job   (i_job),
        .i_pop   (fsm_pop),
        .o_head  (q_head),
        .o_full  (q_full),
        .o_empty (q_empty),
        .o_count (o_count)
    );

    sched_fsm u_sched_fsm (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_empty   (q_empty),
        .i_head    (q_head),
        .i_expire  (tmr_expire),
        .o_pop     (fsm_pop),
        .o_load    (fsm_load),
        .o_len     (fsm_len),
        .o_busy    (fsm_busy),
        .o_done    (o_done),
        .o_done_id (o_done_id)
    );

    job_timer u_job_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_load   (fsm_load),
        .i_len    (fsm_len),
        .o_expire (tmr_expire)
    );

    // Status levels straight from the blocks
    assign o_status = '{busy: fsm_busy, full: q_full, empty: q_empty};

endmodule

`default_nettype wire

//--- src/job_timer.sv
`timescale 1ns/1ps
`default_nettype none

module job_timer (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_load,  // Arms or restarts the count
    input  wire [job_pkg::LEN_W-1:0]  i_len,
    output logic                      o_expire  // One cycle, L+1 cycles after load
);

    logic [job_pkg::LEN_W-1:0] remain;  // Cycles left before expiry
    logic                      active;

    // Fires in the cycle where the count has run out
    assign o_expire = active && (remain == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
            active <= 1'b0;
        end else if (i_load) begin
            remain <= i_len;  // Reload wins over expiry
            active <= 1'b1;
        end else if (o_expire) begin
            active <= 1'b0;
        end else if (active) begin
            remain <= remain - 1'b1;
        end
    end

    // An expiry straight out of idle needs a load one edge back
    a_expire_loaded: assert property (@(posedge clk) disable iff (!rst_n)
        o_expire && !$past(active) |-> $past(i_load));

endmodule

`default_nettype wire

//--- src/prio_queue.sv
`timescale 1ns/1ps
`default_nettype none

module prio_queue #(
    parameter int DEPTH_LOG2      = 3,    // 2**DEPTH_LOG2 entries
    parameter bit HIGH_PRIO_FIRST = 1'b1  // 0 means lower prio value wins
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  i_push,   // Strobe with i_job
    input  wire job_pkg::job_t   i_job,
    input  wire                  i_pop,    // Strobe, head loads on this edge
    output job_pkg::job_t        o_head,   // Last popped entry
    output logic                 o_full,
    output logic                 o_empty,
    output logic [DEPTH_LOG2:0]  o_count
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    typedef logic [DEPTH_LOG2:0] cnt_t;

    // Sorted storage, winner at index 0
    job_pkg::job_t q_mem  [DEPTH];
    job_pkg::job_t q_base [DEPTH];  // After optional pop shift
    job_pkg::job_t q_next [DEPTH];  // After optional insert

    cnt_t count;
    cnt_t base_n;   // Entries left after the pop
    cnt_t ins_idx;  // Slot for the new entry
    logic push_ok;
    logic pop_ok;

    assign o_full  = (count == cnt_t'(DEPTH));
    assign o_empty = (count == '0);
    assign o_count = count;

    // Full blocks a push even when a pop frees a slot this cycle
    assign push_ok = i_push && !o_full;
    assign pop_ok  = i_pop && !o_empty;

    // Strict compare, so equal prio lands behind older entries
    function automatic logic beats(input job_pkg::job_t a, input job_pkg::job_t b);
        if (HIGH_PRIO_FIRST) begin
            return a.prio > b.prio;
        end
        return a.prio < b.prio;
    endfunction

    // Pop first: remaining entries move up one slot
    always_comb begin
        for (int i = 0; i < DEPTH - 1; i++) begin
            q_base[i] = pop_ok ? q_mem[i+1] : q_mem[i];
        end
        q_base[DEPTH-1] = pop_ok ? '0 : q_mem[DEPTH-1];
        base_n = count - cnt_t'(pop_ok);
    end

    // Insert point among the remaining set
    always_comb begin
        ins_idx = base_n;  // Default is behind everything
        // Downward scan leaves the first winning slot
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (cnt_t'(i) < base_n && beats(i_job, q_base[i])) begin
                ins_idx = cnt_t'(i);
            end
        end
    end

    // Open a gap at ins_idx, shift the tail down
    always_comb begin
        q_next[0] = (push_ok && ins_idx == '0) ? i_job : q_base[0];
        for (int i = 1; i < DEPTH; i++) begin
            if (!push_ok || cnt_t'(i) < ins_idx) begin
                q_next[i] = q_base[i];
            end else if (cnt_t'(i) == ins_idx) begin
                q_next[i] = i_job;
            end else begin
                q_next[i] = q_base[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count  <= '0;
            o_head <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                q_mem[i] <= '0;  // Storage cleared too
            end
        end else begin
            if (push_ok || pop_ok) begin
                for (int i = 0; i < DEPTH; i++) begin
                    q_mem[i] <= q_next[i];
                end
            end
            if (pop_ok) begin
                o_head <= q_mem[0];  // Held until the next pop
            end
            count <= base_n + cnt_t'(push_ok);  // Push and pop together keep count
        end
    end

    // Occupancy bound
    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_t'(DEPTH));

    a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(o_full && o_empty));

    // FSM is expected to check empty before popping
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- src/sched_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sched_fsm (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       i_enable,  // Level, gates new starts only
    input  wire                       i_empty,
    input  wire job_pkg::job_t        i_head,    // Valid from S_LOAD on
    input  wire                       i_expire,
    output logic                      o_pop,
    output logic                      o_load,
    output logic [job_pkg::LEN_W-1:0] o_len,
    output logic                      o_busy,
    output logic                      o_done,
    output logic [job_pkg::ID_W-1:0]  o_done_id
);

    sched_pkg::sched_state_e state;
    sched_pkg::sched_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            sched_pkg::S_IDLE: begin
                if (i_enable && !i_empty) begin
                    state_nxt = sched_pkg::S_POP;
                end
            end
            sched_pkg::S_POP:  state_nxt = sched_pkg::S_LOAD;
            sched_pkg::S_LOAD: state_nxt = sched_pkg::S_RUN;
            sched_pkg::S_RUN: begin
                // Running job finishes even with enable low
                if (i_expire) begin
                    state_nxt = sched_pkg::S_IDLE;
                end
            end
            default: state_nxt = sched_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sched_pkg::S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Strobes decoded from state
    assign o_pop  = (state == sched_pkg::S_POP);
    assign o_load = (state == sched_pkg::S_LOAD);
    assign o_len  = i_head.len;  // Head just registered by the pop
    assign o_busy = (state != sched_pkg::S_IDLE);

    // Done in the expiry cycle itself
    assign o_done    = (state == sched_pkg::S_RUN) && i_expire;
    assign o_done_id = i_head.id;  // Head stable until the next pop

    // Pop only follows an idle cycle that saw a waiting job
    a_pop_from_idle: assert property (@(posedge clk) disable iff (!rst_n)
        o_pop |-> $past(state == sched_pkg::S_IDLE && i_enable && !i_empty));

    // Done ends a run and hands the slot back
    a_done_run: assert property (@(posedge clk) disable iff (!rst_n)
        o_done |-> (state == sched_pkg::S_RUN) ##1 (state == sched_pkg::S_IDLE));

endmodule

`default_nettype wire

//--- src/sched_pkg.sv
`default_nettype none

// Scheduler control states and external status
package sched_pkg;

    // FSM states, one pass per job
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,  // Slot free, waiting for enable and a job
        S_POP  = 2'd1,  // Pop strobe to the queue
        S_LOAD = 2'd2,  // Head valid, load timer
        S_RUN  = 2'd3   // Slot busy until timer expiry
    } sched_state_e;

    // Status levels seen by the outside
    typedef struct packed {
        logic busy;   // Job in flight
        logic full;   // Pushes dropped while high
        logic empty;  // No job waiting
    } sched_status_t;

endpackage

`default_nettype wire

//--- include/job_sched_checks.svh
`ifndef JOB_SCHED_CHECKS_SVH
`define JOB_SCHED_CHECKS_SVH

// Compare helpers, included inside the testbench module

task automatic check_id(input string name,
                        input logic [job_pkg::ID_W-1:0] got,
                        input logic [job_pkg::ID_W-1:0] exp);
    if (got !== exp) begin
        $display("mismatch %s got %h exp %h", name, got, exp);
        $display("Some tests failed");
        $fatal(1);
    end
endtask

// Occupancy, pulse levels and cycle totals
task automatic check_count(input string name,
                           input int unsigned got,
                           input int unsigned exp);
    if (got !== exp) begin
        $display("mismatch %s got %h exp %h", name, got, exp);
        $display("Some tests failed");
        $fatal(1);
    end
endtask

task automatic check_status(input string name,
                            input sched_pkg::sched_status_t got,
                            input sched_pkg::sched_status_t exp);
    if (got !== exp) begin
        $display("mismatch %s got %h exp %h", name, got, exp);
        $display("Some tests failed");
        $fatal(1);
    end
endtask

`endif

//--- tests/tb_job_sched.sv
`timescale 1ns/1ps
`default_nettype none

module tb_job_sched;

    localparam int DEPTH = 8;

    // One table row: drive, then idle, then optionally wait for the drain
    typedef struct packed {
        logic          push;
        job_pkg::job_t job;
        logic          enable;
        logic [3:0]    idle;    // Extra cycles after the drive edge
        logic          drain;   // Wait until queue empty and slot idle
    } step_t;

    logic                     clk;
    logic                     rst_n;
    logic                     i_push;
    job_pkg::job_t            i_job;
    logic                     i_enable;
    logic                     o_done;
    logic [job_pkg::ID_W-1:0] o_done_id;
    sched_pkg::sched_status_t o_status;
    logic [3:0]               o_count;

    step_t                    steps[$];
    job_pkg::job_t            model_q[$];  // Sorted, winner first
    job_pkg::job_t            m_head;      // Last popped job
    sched_pkg::sched_state_e  m_state;
    int                       m_remain;
    logic                     push_ok;
    logic [job_pkg::ID_W-1:0] done_ids[$];
    logic [job_pkg::ID_W-1:0] exp_order[8] = '{4'd4, 4'd2, 4'd6, 4'd1, 4'd3, 4'd7, 4'd5, 4'd8};
    int                       busy_cnt = 0;
    int                       cycles   = 0;
    int                       limit    = 0;
    int                       seed     = 32'hb2d03923;
    sched_pkg::sched_status_t exp_status;

    `include "job_sched_checks.svh"

    job_sched_top u_job_sched_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_push    (i_push),
        .i_job     (i_job),
        .i_enable  (i_enable),
        .o_done    (o_done),
        .o_done_id (o_done_id),
        .o_status  (o_status),
        .o_count   (o_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic step_t make_step(input logic push, input int id, input int prio,
                                        input int len, input logic en, input int idle,
                                        input logic drain);
        step_t s;
        s.push     = push;
        s.job.id   = job_pkg::ID_W'(id);
        s.job.prio = job_pkg::PRIO_W'(prio);
        s.job.len  = job_pkg::LEN_W'(len);
        s.enable   = en;
        s.idle     = 4'(idle);
        s.drain    = drain;
        return s;
    endfunction

    // Higher prio wins, equal prio goes behind older entries
    task automatic insert_job(input job_pkg::job_t j);
        int idx;
        idx = model_q.size();
        for (int i = model_q.size() - 1; i >= 0; i--) begin
            if (j.prio > model_q[i].prio) idx = i;
        end
        model_q.insert(idx, j);
    endtask

    // Reference model of queue and FSM, pre-edge inputs
    always @(posedge clk) begin
        if (rst_n) begin
            push_ok = i_push && (model_q.size() < DEPTH);  // Full checked before the pop
            case (m_state)
                sched_pkg::S_IDLE: if (i_enable && model_q.size() != 0) m_state = sched_pkg::S_POP;
                sched_pkg::S_POP: begin
                    m_head  = model_q.pop_front();
                    m_state = sched_pkg::S_LOAD;
                end
                sched_pkg::S_LOAD: begin
                    m_remain = m_head.len;  // L+1 run cycles follow
                    m_state  = sched_pkg::S_RUN;
                end
                default: begin
                    if (m_remain == 0) m_state = sched_pkg::S_IDLE;
                    else m_remain--;
                end
            endcase
            if (push_ok) insert_job(i_job);  // Among entries left after the pop
        end
    end

    // Outputs compared mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            exp_status.busy  = (m_state != sched_pkg::S_IDLE);
            exp_status.full  = (model_q.size() == DEPTH);
            exp_status.empty = (model_q.size() == 0);
            check_status("o_status", o_status, exp_status);
            check_count("o_count", o_count, model_q.size());
            check_count("o_done", o_done, m_state == sched_pkg::S_RUN && m_remain == 0);
            if (o_status.busy) busy_cnt++;
            if (o_done) begin
                check_id("o_done_id", o_done_id, m_head.id);
                check_count("busy_cycles", busy_cnt, m_head.len + 3);  // POP, LOAD, L+1 runs
                done_ids.push_back(o_done_id);
                busy_cnt = 0;
            end
        end
    end

    // Run guard
    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Some tests failed");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", limit);
        end
    end

    task automatic apply_step(input step_t s);
        @(posedge clk);
        i_push   <= s.push;
        i_job    <= s.job;
        i_enable <= s.enable;
        repeat (s.idle) begin
            @(posedge clk);
            i_push <= 1'b0;
        end
        if (s.drain) begin
            @(posedge clk);
            i_push <= 1'b0;
            @(negedge clk);
            while (model_q.size() != 0 || m_state != sched_pkg::S_IDLE) @(negedge clk);
        end
    endtask

    initial begin
        int rnd;
        rst_n    = 1'b0;
        i_push   = 1'b0;
        i_job    = '0;
        i_enable = 1'b0;
        m_state  = sched_pkg::S_IDLE;
        m_remain = 0;
        m_head   = '0;
        // Eight mixed jobs with enable low, then a ninth while full
        steps.push_back(make_step(1, 1, 3, 2, 0, 0, 0));
        steps.push_back(make_step(1, 2, 5, 0, 0, 0, 0));
        steps.push_back(make_step(1, 3, 3, 1, 0, 1, 0));
        steps.push_back(make_step(1, 4, 7, 3, 0, 0, 0));
        steps.push_back(make_step(1, 5, 1, 0, 0, 2, 0));
        steps.push_back(make_step(1, 6, 5, 2, 0, 0, 0));
        steps.push_back(make_step(1, 7, 3, 0, 0, 0, 0));
        steps.push_back(make_step(1, 8, 0, 1, 0, 0, 0));
        steps.push_back(make_step(1, 9, 7, 1, 0, 1, 0));  // Dropped
        steps.push_back(make_step(0, 0, 0, 0, 1, 0, 1));
        // Random pushes while jobs run and pop
        for (int i = 0; i < 24; i++) begin
            rnd = $random(seed);
            steps.push_back(make_step(1, i % 16, rnd[2:0], rnd[7:4], 1, rnd[9:8], 0));
        end
        steps.push_back(make_step(0, 0, 0, 0, 1, 0, 1));
        limit = 200 + 16;
        foreach (steps[i]) begin
            limit += 1 + steps[i].idle;
            if (steps[i].push) limit += steps[i].job.len + 4;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        exp_status = '{busy: 1'b0, full: 1'b0, empty: 1'b1};  // Reset levels
        check_status("o_status", o_status, exp_status);
        check_count("o_count", o_count, 0);
        check_count("o_done", o_done, 0);
        @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 10; i++) apply_step(steps[i]);
        // Descending prio, ties in push order, id 9 never seen
        check_count("done_total", done_ids.size(), 8);
        foreach (exp_order[i]) check_id("done_order", done_ids[i], exp_order[i]);
        for (int i = 10; i < steps.size(); i++) apply_step(steps[i]);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
src/job_pkg.sv
src/sched_pkg.sv
src/prio_queue.sv
src/job_timer.sv
src/sched_fsm.sv
src/job_sched_top.sv
tests/tb_job_sched.sv
